// File: dv/id_stage_stim.txt
# grp inst pc rdata1 rdata2 flush drop | expected: alu br mem imm wreg_en wreg_idx
# reg_index2 inst_valid src1_sel src2_sel (sel 0 reg, 1 imm, 2 pc), all hex but grp
1 00101483 1c000000 11111111 22222222 0 0 001 00 00 00000000 1 03 05 1 0 0
1 00111483 1c000004 a5a5a5a5 5a5a5a5a 0 0 008 00 00 00000000 1 03 05 1 0 0
1 00141483 1c000008 00000001 80000000 0 0 400 00 00 00000000 1 03 05 1 0 0
1 00181483 1c00000c fedcba98 00000004 0 0 020 00 00 00000000 1 03 05 1 0 0
1 00129483 1c000010 0000ffff ffff0000 0 0 200 00 00 00000000 1 03 05 1 0 0
2 02bffc83 1c000014 00000010 00000000 0 0 001 00 00 ffffffff 1 03 1f 1 0 1
2 03600083 1c000018 00000020 00000000 0 0 040 00 00 00000800 1 03 00 1 0 1
2 021ffc83 1c00001c 00000030 00000000 0 0 800 00 00 000007ff 1 03 1f 1 0 1
2 0048fc83 1c000020 80000000 00000000 0 0 020 00 00 0000001f 1 03 1f 1 0 1
2 15000023 1c000024 00000000 00000000 0 0 002 00 00 80001000 1 03 00 1 1 1
2 1c000203 1c000028 00000000 00000000 0 0 001 00 00 00010000 1 03 00 1 1 2
3 5bfff883 1c00002c 00000005 00000005 0 0 001 08 00 fffffff8 0 03 03 1 2 1
3 540013ff 1c000030 00000000 00000000 0 0 001 02 00 fffc0010 1 01 04 1 2 1
3 4c004083 1c000034 1c000100 00000000 0 0 001 01 00 00000040 1 03 10 1 0 1
3 50040000 1c000038 00000000 00000000 0 0 001 02 00 00000400 0 00 00 1 2 1
4 28001083 1c00003c 00001000 00000000 0 0 001 00 21 00000004 1 03 04 1 0 1
4 2a7ff083 1c000040 00002000 00000000 0 0 001 00 13 fffffffc 1 03 1c 1 0 1
4 29802083 1c000044 00003000 deadbeef 0 0 001 00 0d 00000008 0 03 03 1 0 1
4 29600083 1c000048 00004000 0000beef 0 0 001 00 15 fffff800 0 03 03 1 0 1
5 00101483 1c00004c 00000001 00000002 1 1 001 00 00 00000000 1 03 05 1 0 0
5 00111483 1c000050 00000009 00000003 0 0 008 00 00 00000000 1 03 05 1 0 0
5 00159483 1c000054 00000007 00000007 1 1 010 00 00 00000000 1 03 05 1 0 0
5 00151483 1c000058 000000f0 0000000f 0 0 004 00 00 00000000 1 03 05 1 0 0
6 ffffffff 1c00005c 12345678 87654321 0 0 000 00 00 00000000 0 1f 1f 0 0 0
6 00000000 1c000060 00000000 00000000 0 0 000 00 00 00000000 0 00 00 0 0 0

// File: build.f
+incdir+source
source/la_decode_pkg.sv
source/inst_field_decode.sv
source/operand_builder.sv
source/id_stage_reg.sv
source/id_stage.sv
dv/id_stage_chk.sv
dv/id_stage_tb.sv

// File: dv/id_stage_tb.sv
`default_nettype none

`include "la_decode_config.svh"

module id_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_LINES = 64;

    logic                            clk;
    logic                            reset;
    logic                            flush;
    logic [`LA_INST_W-1:0]           inst;
    logic [`LA_INST_W-1:0]           pc;
    logic                            left_valid;
    logic                            right_ready;
    logic [`LA_INST_W-1:0]           reg_data1;
    logic [`LA_INST_W-1:0]           reg_data2;
    wire                             left_ready;
    wire                             right_valid;
    wire [`LA_REG_IDX_W-1:0]         reg_index1;
    wire [`LA_REG_IDX_W-1:0]         reg_index2;
    la_decode_pkg::alu_op_t          alu_op;
    la_decode_pkg::branch_op_t       branch_op;
    la_decode_pkg::mem_op_t          mem_op;
    la_decode_pkg::src_sel_t         src1_sel;
    la_decode_pkg::src_sel_t         src2_sel;
    wire [`LA_INST_W-1:0]            imm;
    wire [`LA_INST_W-1:0]            src1;
    wire [`LA_INST_W-1:0]            src2;
    wire                             wreg_en;
    wire [`LA_REG_IDX_W-1:0]         wreg_index;
    wire                             inst_valid;
    wire [`LA_INST_W-1:0]            pc_out;

    // one entry per stim line
    int                        grp_a[MAX_LINES];
    logic [`LA_INST_W-1:0]     inst_a[MAX_LINES];
    logic [`LA_INST_W-1:0]     pc_a[MAX_LINES];
    logic [`LA_INST_W-1:0]     d1_a[MAX_LINES];
    logic [`LA_INST_W-1:0]     d2_a[MAX_LINES];
    logic                      flush_a[MAX_LINES];
    logic                      drop_a[MAX_LINES];
    la_decode_pkg::alu_op_t    alu_a[MAX_LINES];
    la_decode_pkg::branch_op_t br_a[MAX_LINES];
    la_decode_pkg::mem_op_t    mem_a[MAX_LINES];
    logic [`LA_INST_W-1:0]     imm_a[MAX_LINES];
    logic                      wen_a[MAX_LINES];
    logic [`LA_REG_IDX_W-1:0]  widx_a[MAX_LINES];
    logic [`LA_REG_IDX_W-1:0]  ridx2_a[MAX_LINES];
    logic                      ival_a[MAX_LINES];
    logic [1:0]                s1_a[MAX_LINES];
    logic [1:0]                s2_a[MAX_LINES];

    int n_lines = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit = 0;
    int cur_grp = 0;
    int grp_items = 0;
    int grp_err_start = 0;
    int exp_q[$];

    id_stage dut0 (.*);

    always #5 clk = ~clk;

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_group();
        $display("group %0d done: %0d items, %0d errors", cur_grp, grp_items,
                 errors - grp_err_start);
    endtask

    task automatic load_stim();
        int fd;
        int cnt;
        string line;
        fd = $fopen("dv/id_stage_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              grp_a[n_lines], inst_a[n_lines], pc_a[n_lines],
                              d1_a[n_lines], d2_a[n_lines], flush_a[n_lines],
                              drop_a[n_lines], alu_a[n_lines], br_a[n_lines],
                              mem_a[n_lines], imm_a[n_lines], wen_a[n_lines],
                              widx_a[n_lines], ridx2_a[n_lines], ival_a[n_lines],
                              s1_a[n_lines], s2_a[n_lines]);
                assert (cnt == 17) else begin
                    $display("malformed stimulus line: %s", line);
                    errors++;
                end
                n_lines++;
            end
            $fclose(fd);
        end
    endtask

    // random back-pressure
    initial begin
        void'($urandom(32'h5918_e770));
        forever begin
            @(posedge clk);
            right_ready <= ($urandom % 10) < 7;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, instructions still outstanding", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // in-order scoreboard
    always @(posedge clk) begin
        int idx;
        if (!reset && right_valid && right_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("an instruction came out that was flushed or never sent");
                errors++;
            end
            if (exp_q.size() > 0) begin
                idx = exp_q.pop_front();
                if (grp_a[idx] != cur_grp) begin
                    if (cur_grp != 0) begin
                        report_group();
                    end
                    cur_grp = grp_a[idx];
                    grp_items = 0;
                    grp_err_start = errors;
                end
                grp_items++;
                check_field("alu_op", alu_a[idx], alu_op);
                check_field("branch_op", br_a[idx], branch_op);
                check_field("mem_op", mem_a[idx], mem_op);
                check_field("imm", imm_a[idx], imm);
                check_field("wreg_en", wen_a[idx], wreg_en);
                check_field("wreg_index", widx_a[idx], wreg_index);
                check_field("inst_valid", ival_a[idx], inst_valid);
                check_field("src1_sel", s1_a[idx], src1_sel);
                check_field("src2_sel", s2_a[idx], src2_sel);
                check_field("src1", d1_a[idx], src1);
                check_field("src2", d2_a[idx], src2);
                check_field("pc_out", pc_a[idx], pc_out);
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        inst = '0;
        pc = '0;
        left_valid = 1'b0;
        right_ready = 1'b0;
        reg_data1 = '0;
        reg_data2 = '0;
        load_stim();
        cycle_limit = 40 * n_lines + 100;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < n_lines; i++) begin
            // a flush must not catch an older instruction still in the stage
            if (flush_a[i]) begin
                left_valid <= 1'b0;
                flush <= 1'b0;
                while (exp_q.size() != 0 || right_valid) @(posedge clk);
            end
            inst <= inst_a[i];
            pc <= pc_a[i];
            reg_data1 <= d1_a[i];
            reg_data2 <= d2_a[i];
            flush <= flush_a[i];
            left_valid <= 1'b1;
            @(negedge clk);
            // rj sits in bits 9:5 of every encoding
            check_field("reg_index1", inst_a[i][9:5], reg_index1);
            check_field("reg_index2", ridx2_a[i], reg_index2);
            do @(posedge clk); while (!left_ready);
            if (!drop_a[i]) begin
                exp_q.push_back(i);
            end
        end
        left_valid <= 1'b0;
        flush <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        if (cur_grp != 0) begin
            report_group();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/id_stage_chk.sv
`default_nettype none

`include "la_decode_config.svh"

module id_stage_chk (
    input wire                   clk,
    input wire                   reset,
    input wire                   flush,
    input wire                   left_ready,
    input wire                   right_ready,
    input wire                   right_valid,
    input wire                   wreg_en,
    input wire                   inst_valid,
    input wire [11:0]            alu_op,
    input wire [`LA_INST_W-1:0]  imm,
    input wire [`LA_INST_W-1:0]  src1,
    input wire [`LA_INST_W-1:0]  src2,
    input wire [`LA_INST_W-1:0]  pc_out
);

    timeunit 1ns;
    timeprecision 1ps;

    valid_after_reset: assert property (@(posedge clk) reset |=> !right_valid)
        else $error("right_valid high after reset");

    ready_passthrough: assert property (@(posedge clk) left_ready == right_ready)
        else $error("left_ready differs from right_ready");

    // stalled output holds
    hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        right_valid && !right_ready && !flush
        |=> right_valid && $stable(alu_op) && $stable(imm) && $stable(src1)
            && $stable(src2) && $stable(pc_out))
        else $error("output changed while stalled");

    write_needs_valid: assert property (@(posedge clk) wreg_en |-> inst_valid)
        else $error("wreg_en set for an unrecognised instruction");

endmodule

bind id_stage id_stage_chk chk0 (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .left_ready  (left_ready),
    .right_ready (right_ready),
    .right_valid (right_valid),
    .wreg_en     (wreg_en),
    .inst_valid  (inst_valid),
    .alu_op      (alu_op),
    .imm         (imm),
    .src1        (src1),
    .src2        (src2),
    .pc_out      (pc_out)
);

`default_nettype wire

// File: source/id_stage.sv
`default_nettype none

`include "la_decode_config.svh"

module id_stage (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             flush,
    input  wire [`LA_INST_W-1:0]            inst,
    input  wire [`LA_INST_W-1:0]            pc,
    input  wire                             left_valid,
    output wire                             left_ready,
    output wire                             right_valid,
    input  wire                             right_ready,
    output wire [`LA_REG_IDX_W-1:0]         reg_index1,
    output wire [`LA_REG_IDX_W-1:0]         reg_index2,
    input  wire [`LA_INST_W-1:0]            reg_data1,
    input  wire [`LA_INST_W-1:0]            reg_data2,
    output la_decode_pkg::alu_op_t          alu_op,
    output la_decode_pkg::branch_op_t       branch_op,
    output la_decode_pkg::mem_op_t          mem_op,
    output la_decode_pkg::src_sel_t         src1_sel,
    output la_decode_pkg::src_sel_t         src2_sel,
    output wire [`LA_INST_W-1:0]            imm,
    output wire [`LA_INST_W-1:0]            src1,
    output wire [`LA_INST_W-1:0]            src2,
    output wire                             wreg_en,
    output wire [`LA_REG_IDX_W-1:0]         wreg_index,
    output wire                             inst_valid,
    output wire [`LA_INST_W-1:0]            pc_out
);

    la_decode_pkg::alu_op_t     dec_alu_op;
    la_decode_pkg::branch_op_t  dec_branch_op;
    la_decode_pkg::mem_op_t     dec_mem_op;
    la_decode_pkg::imm_kind_t   dec_imm_kind;
    la_decode_pkg::src_sel_t    dec_src1_sel;
    la_decode_pkg::src_sel_t    dec_src2_sel;
    logic                       dec_rd_is_src2;
    logic                       dec_link_write;
    logic                       dec_wreg_en;
    logic                       dec_inst_valid;
    logic [`LA_INST_W-1:0]      dec_imm;
    logic [`LA_REG_IDX_W-1:0]   dec_wreg_index;

    // opcode match
    inst_field_decode u_decode (
        .inst       (inst),
        .alu_op     (dec_alu_op),
        .branch_op  (dec_branch_op),
        .mem_op     (dec_mem_op),
        .imm_kind   (dec_imm_kind),
        .src1_sel   (dec_src1_sel),
        .src2_sel   (dec_src2_sel),
        .rd_is_src2 (dec_rd_is_src2),
        .link_write (dec_link_write),
        .wreg_en    (dec_wreg_en),
        .inst_valid (dec_inst_valid)
    );

    // immediate and register indices
    operand_builder u_operand (
        .inst       (inst),
        .imm_kind   (dec_imm_kind),
        .rd_is_src2 (dec_rd_is_src2),
        .link_write (dec_link_write),
        .imm        (dec_imm),
        .reg_index1 (reg_index1),
        .reg_index2 (reg_index2),
        .wreg_index (dec_wreg_index)
    );

    id_stage_reg u_stage_reg (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .left_valid   (left_valid),
        .right_ready  (right_ready),
        .left_ready   (left_ready),
        .right_valid  (right_valid),
        .alu_op       (dec_alu_op),
        .branch_op    (dec_branch_op),
        .mem_op       (dec_mem_op),
        .src1_sel     (dec_src1_sel),
        .src2_sel     (dec_src2_sel),
        .imm          (dec_imm),
        .wreg_en      (dec_wreg_en),
        .wreg_index   (dec_wreg_index),
        .inst_valid   (dec_inst_valid),
        .pc           (pc),
        .reg_data1    (reg_data1),
        .reg_data2    (reg_data2),
        .alu_op_q     (alu_op),
        .branch_op_q  (branch_op),
        .mem_op_q     (mem_op),
        .src1_sel_q   (src1_sel),
        .src2_sel_q   (src2_sel),
        .imm_q        (imm),
        .src1         (src1),
        .src2         (src2),
        .wreg_en_q    (wreg_en),
        .wreg_index_q (wreg_index),
        .inst_valid_q (inst_valid),
        .pc_q         (pc_out)
    );

endmodule

`default_nettype wire

// File: source/id_stage_reg.sv
`default_nettype none

`include "la_decode_config.svh"

module id_stage_reg (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             flush,
    input  wire                             left_valid,
    input  wire                             right_ready,
    output logic                            left_ready,
    output logic                            right_valid,
    input  wire la_decode_pkg::alu_op_t     alu_op,
    input  wire la_decode_pkg::branch_op_t  branch_op,
    input  wire la_decode_pkg::mem_op_t     mem_op,
    input  wire la_decode_pkg::src_sel_t    src1_sel,
    input  wire la_decode_pkg::src_sel_t    src2_sel,
    input  wire [`LA_INST_W-1:0]            imm,
    input  wire                             wreg_en,
    input  wire [`LA_REG_IDX_W-1:0]         wreg_index,
    input  wire                             inst_valid,
    input  wire [`LA_INST_W-1:0]            pc,
    input  wire [`LA_INST_W-1:0]            reg_data1,
    input  wire [`LA_INST_W-1:0]            reg_data2,
    output la_decode_pkg::alu_op_t          alu_op_q,
    output la_decode_pkg::branch_op_t       branch_op_q,
    output la_decode_pkg::mem_op_t          mem_op_q,
    output la_decode_pkg::src_sel_t         src1_sel_q,
    output la_decode_pkg::src_sel_t         src2_sel_q,
    output logic [`LA_INST_W-1:0]           imm_q,
    output logic [`LA_INST_W-1:0]           src1,
    output logic [`LA_INST_W-1:0]           src2,
    output logic                            wreg_en_q,
    output logic [`LA_REG_IDX_W-1:0]        wreg_index_q,
    output logic                            inst_valid_q,
    output logic [`LA_INST_W-1:0]           pc_q
);

    logic accept;

    // stage only takes a new word when execute can take the old one
    assign left_ready = right_ready;
    assign accept     = left_valid & left_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            right_valid <= 1'b0;
        end else if (accept) begin
            right_valid <= 1'b1;
        end else if (right_valid && !right_ready) begin
            right_valid <= 1'b1;
        end else begin
            right_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_op_q     <= '0;
            branch_op_q  <= '0;
            mem_op_q     <= '0;
            src1_sel_q   <= la_decode_pkg::SRC_REG;
            src2_sel_q   <= la_decode_pkg::SRC_REG;
            imm_q        <= '0;
            src1         <= '0;
            src2         <= '0;
            wreg_en_q    <= 1'b0;
            wreg_index_q <= '0;
            inst_valid_q <= 1'b0;
            pc_q         <= '0;
        end else if (accept) begin
            alu_op_q     <= alu_op;
            branch_op_q  <= branch_op;
            mem_op_q     <= mem_op;
            src1_sel_q   <= src1_sel;
            src2_sel_q   <= src2_sel;
            imm_q        <= imm;
            // register file answers in the cycle of the read
            src1         <= reg_data1;
            src2         <= reg_data2;
            wreg_en_q    <= wreg_en;
            wreg_index_q <= wreg_index;
            inst_valid_q <= inst_valid;
            pc_q         <= pc;
        end
    end

endmodule

`default_nettype wire

// File: source/operand_builder.sv
`default_nettype none

`include "la_decode_config.svh"

module operand_builder (
    input  wire [`LA_INST_W-1:0]       inst,
    input  wire la_decode_pkg::imm_kind_t imm_kind,
    input  wire                        rd_is_src2,
    input  wire                        link_write,
    output logic [`LA_INST_W-1:0]      imm,
    output logic [`LA_REG_IDX_W-1:0]   reg_index1,
    output logic [`LA_REG_IDX_W-1:0]   reg_index2,
    output logic [`LA_REG_IDX_W-1:0]   wreg_index
);

    logic [`LA_REG_IDX_W-1:0] rd;
    logic [`LA_REG_IDX_W-1:0] rj;
    logic [`LA_REG_IDX_W-1:0] rk;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    always_comb begin
        case (imm_kind)
            la_decode_pkg::IMM_SI12: begin
                imm = {{(`LA_INST_W-12){inst[21]}}, inst[21:10]};
            end
            la_decode_pkg::IMM_UI12: begin
                imm = {{(`LA_INST_W-12){1'b0}}, inst[21:10]};
            end
            // word offsets, low two bits dropped from the encoding
            la_decode_pkg::IMM_I16: begin
                imm = {{(`LA_INST_W-18){inst[25]}}, inst[25:10], 2'b00};
            end
            // offset high part sits in bits 9:0
            la_decode_pkg::IMM_I26: begin
                imm = {{(`LA_INST_W-28){inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            end
            la_decode_pkg::IMM_I20: begin
                imm = {inst[24:5], 12'h000};
            end
            la_decode_pkg::IMM_UI5: begin
                imm = {{(`LA_INST_W-5){1'b0}}, inst[14:10]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    assign reg_index1 = rj;
    assign reg_index2 = rd_is_src2 ? rd : rk;
    assign wreg_index = link_write ? `LA_LINK_REG : rd;

endmodule

`default_nettype wire

// File: source/inst_field_decode.sv
`default_nettype none

`include "la_decode_config.svh"

module inst_field_decode (
    input  wire [`LA_INST_W-1:0]        inst,
    output la_decode_pkg::alu_op_t      alu_op,
    output la_decode_pkg::branch_op_t   branch_op,
    output la_decode_pkg::mem_op_t      mem_op,
    output la_decode_pkg::imm_kind_t    imm_kind,
    output la_decode_pkg::src_sel_t     src1_sel,
    output la_decode_pkg::src_sel_t     src2_sel,
    output logic                        rd_is_src2,
    output logic                        link_write,
    output logic                        wreg_en,
    output logic                        inst_valid
);

    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [1:0] op_21_20;
    logic [4:0] op_19_15;
    logic       grp_op0;
    logic       grp_3r;
    logic       grp_shi;
    logic       grp_mem;
    logic inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and;
    logic inst_or, inst_xor, inst_sll, inst_srl, inst_sra;
    logic inst_slli, inst_srli, inst_srai;
    logic inst_slti, inst_sltui, inst_addi, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i, inst_pcaddu12i;
    logic inst_jirl, inst_b, inst_bl;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic inst_st_b, inst_st_h, inst_st_w;
    logic is_load;
    logic is_store;
    logic is_cond_br;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    // opcode groups sharing upper fields
    assign grp_op0 = (op_31_26 == 6'h00);
    assign grp_3r  = grp_op0 & (op_25_22 == 4'h0) & (op_21_20 == 2'h1);
    assign grp_shi = grp_op0 & (op_25_22 == 4'h1) & (op_21_20 == 2'h0);
    assign grp_mem = (op_31_26 == 6'h0a);

    // three-register alu
    assign inst_add  = grp_3r & (op_19_15 == 5'h00);
    assign inst_sub  = grp_3r & (op_19_15 == 5'h02);
    assign inst_slt  = grp_3r & (op_19_15 == 5'h04);
    assign inst_sltu = grp_3r & (op_19_15 == 5'h05);
    assign inst_nor  = grp_3r & (op_19_15 == 5'h08);
    assign inst_and  = grp_3r & (op_19_15 == 5'h09);
    assign inst_or   = grp_3r & (op_19_15 == 5'h0a);
    assign inst_xor  = grp_3r & (op_19_15 == 5'h0b);
    assign inst_sll  = grp_3r & (op_19_15 == 5'h0e);
    assign inst_srl  = grp_3r & (op_19_15 == 5'h0f);
    assign inst_sra  = grp_3r & (op_19_15 == 5'h10);

    // shift by immediate
    assign inst_slli = grp_shi & (op_19_15 == 5'h01);
    assign inst_srli = grp_shi & (op_19_15 == 5'h09);
    assign inst_srai = grp_shi & (op_19_15 == 5'h11);

    // 12-bit immediate forms
    assign inst_slti  = grp_op0 & (op_25_22 == 4'h8);
    assign inst_sltui = grp_op0 & (op_25_22 == 4'h9);
    assign inst_addi  = grp_op0 & (op_25_22 == 4'ha);
    assign inst_andi  = grp_op0 & (op_25_22 == 4'hd);
    assign inst_ori   = grp_op0 & (op_25_22 == 4'he);
    assign inst_xori  = grp_op0 & (op_25_22 == 4'hf);

    assign inst_lu12i     = (op_31_26 == 6'h05) & ~inst[25];
    assign inst_pcaddu12i = (op_31_26 == 6'h07) & ~inst[25];

    assign inst_jirl = (op_31_26 == 6'h13);
    assign inst_b    = (op_31_26 == 6'h14);
    assign inst_bl   = (op_31_26 == 6'h15);
    assign inst_beq  = (op_31_26 == 6'h16);
    assign inst_bne  = (op_31_26 == 6'h17);
    assign inst_blt  = (op_31_26 == 6'h18);
    assign inst_bge  = (op_31_26 == 6'h19);
    assign inst_bltu = (op_31_26 == 6'h1a);
    assign inst_bgeu = (op_31_26 == 6'h1b);

    assign inst_ld_b  = grp_mem & (op_25_22 == 4'h0);
    assign inst_ld_h  = grp_mem & (op_25_22 == 4'h1);
    assign inst_ld_w  = grp_mem & (op_25_22 == 4'h2);
    assign inst_st_b  = grp_mem & (op_25_22 == 4'h4);
    assign inst_st_h  = grp_mem & (op_25_22 == 4'h5);
    assign inst_st_w  = grp_mem & (op_25_22 == 4'h6);
    assign inst_ld_bu = grp_mem & (op_25_22 == 4'h8);
    assign inst_ld_hu = grp_mem & (op_25_22 == 4'h9);

    assign is_load    = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store   = inst_st_b | inst_st_h | inst_st_w;
    assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign alu_op[la_decode_pkg::ALU_ADD]  = inst_add | inst_addi | inst_pcaddu12i | inst_jirl
                                           | inst_b | inst_bl | is_cond_br | is_load | is_store;
    assign alu_op[la_decode_pkg::ALU_LUI]  = inst_lu12i;
    assign alu_op[la_decode_pkg::ALU_OR]   = inst_or | inst_ori;
    assign alu_op[la_decode_pkg::ALU_SUB]  = inst_sub;
    assign alu_op[la_decode_pkg::ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[la_decode_pkg::ALU_SRA]  = inst_sra | inst_srai;
    assign alu_op[la_decode_pkg::ALU_AND]  = inst_and | inst_andi;
    assign alu_op[la_decode_pkg::ALU_SLL]  = inst_sll | inst_slli;
    assign alu_op[la_decode_pkg::ALU_SRL]  = inst_srl | inst_srli;
    assign alu_op[la_decode_pkg::ALU_SLTU] = inst_sltu | inst_sltui;
    assign alu_op[la_decode_pkg::ALU_NOR]  = inst_nor;
    assign alu_op[la_decode_pkg::ALU_SLT]  = inst_slt | inst_slti;

    assign branch_op[la_decode_pkg::BR_JIRL] = inst_jirl;
    assign branch_op[la_decode_pkg::BR_B]    = inst_b | inst_bl;
    assign branch_op[la_decode_pkg::BR_BGE]  = inst_bge;
    assign branch_op[la_decode_pkg::BR_BEQ]  = inst_beq;
    assign branch_op[la_decode_pkg::BR_BGEU] = inst_bgeu;
    assign branch_op[la_decode_pkg::BR_BLT]  = inst_blt;
    assign branch_op[la_decode_pkg::BR_BNE]  = inst_bne;
    assign branch_op[la_decode_pkg::BR_BLTU] = inst_bltu;

    assign mem_op[la_decode_pkg::MEM_EN]    = is_load | is_store;
    assign mem_op[la_decode_pkg::MEM_UNS]   = inst_ld_bu | inst_ld_hu;
    assign mem_op[la_decode_pkg::MEM_STORE] = is_store;
    assign mem_op[la_decode_pkg::MEM_WORD]  = inst_ld_w | inst_st_w;
    assign mem_op[la_decode_pkg::MEM_HALF]  = inst_ld_h | inst_ld_hu | inst_st_h;
    assign mem_op[la_decode_pkg::MEM_BYTE]  = inst_ld_b | inst_ld_bu | inst_st_b;

    always_comb begin
        if (inst_addi | inst_slti | inst_sltui | is_load | is_store) begin
            imm_kind = la_decode_pkg::IMM_SI12;
        end else if (inst_andi | inst_ori | inst_xori) begin
            imm_kind = la_decode_pkg::IMM_UI12;
        end else if (inst_jirl | is_cond_br) begin
            imm_kind = la_decode_pkg::IMM_I16;
        end else if (inst_b | inst_bl) begin
            imm_kind = la_decode_pkg::IMM_I26;
        end else if (inst_lu12i | inst_pcaddu12i) begin
            imm_kind = la_decode_pkg::IMM_I20;
        end else if (inst_slli | inst_srli | inst_srai) begin
            imm_kind = la_decode_pkg::IMM_UI5;
        end else begin
            imm_kind = la_decode_pkg::IMM_NONE;
        end
    end

    // branch targets are pc relative, jirl is rj relative
    always_comb begin
        if (inst_b | inst_bl | is_cond_br) begin
            src1_sel = la_decode_pkg::SRC_PC;
        end else if (inst_lu12i | inst_pcaddu12i) begin
            src1_sel = la_decode_pkg::SRC_IMM;
        end else begin
            src1_sel = la_decode_pkg::SRC_REG;
        end
        if (inst_pcaddu12i) begin
            src2_sel = la_decode_pkg::SRC_PC;
        end else if (imm_kind != la_decode_pkg::IMM_NONE) begin
            src2_sel = la_decode_pkg::SRC_IMM;
        end else begin
            src2_sel = la_decode_pkg::SRC_REG;
        end
    end

    // stores and compares read rd as the second operand
    assign rd_is_src2 = is_store | is_cond_br;
    assign link_write = inst_bl;

    // every kept instruction sets exactly one alu bit
    assign inst_valid = |alu_op;
    assign wreg_en    = inst_valid & ~is_store & ~is_cond_br & ~inst_b;

endmodule

`default_nettype wire

// File: source/la_decode_pkg.sv
`default_nettype none

package la_decode_pkg;

    // one-hot alu operation, bit positions below
    typedef logic [11:0] alu_op_t;

    // add also serves address and branch target computation
    localparam int ALU_ADD  = 0;
    localparam int ALU_LUI  = 1;
    localparam int ALU_OR   = 2;
    localparam int ALU_SUB  = 3;
    localparam int ALU_XOR  = 4;
    localparam int ALU_SRA  = 5;
    localparam int ALU_AND  = 6;
    localparam int ALU_SLL  = 7;
    localparam int ALU_SRL  = 8;
    localparam int ALU_SLTU = 9;
    localparam int ALU_NOR  = 10;
    localparam int ALU_SLT  = 11;

    // one-hot branch kind
    typedef logic [7:0] branch_op_t;

    localparam int BR_JIRL = 0;
    localparam int BR_B    = 1;
    localparam int BR_BGE  = 2;
    localparam int BR_BEQ  = 3;
    localparam int BR_BGEU = 4;
    localparam int BR_BLT  = 5;
    localparam int BR_BNE  = 6;
    localparam int BR_BLTU = 7;

    // memory access flags
    typedef logic [5:0] mem_op_t;

    localparam int MEM_EN    = 0;
    localparam int MEM_UNS   = 1;
    localparam int MEM_STORE = 2;
    localparam int MEM_WORD  = 3;
    localparam int MEM_HALF  = 4;
    localparam int MEM_BYTE  = 5;

    // operand source for execute
    typedef enum logic [1:0] {
        SRC_REG = 2'd0,
        SRC_IMM = 2'd1,
        SRC_PC  = 2'd2
    } src_sel_t;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_SI12 = 3'd1,
        IMM_UI12 = 3'd2,
        IMM_I16  = 3'd3,
        IMM_I26  = 3'd4,
        IMM_I20  = 3'd5,
        IMM_UI5  = 3'd6
    } imm_kind_t;

endpackage

`default_nettype wire

// File: source/la_decode_config.svh
`ifndef LA_DECODE_CONFIG_SVH
`define LA_DECODE_CONFIG_SVH

// instruction word and data path width
`define LA_INST_W 32

// register file index width
`define LA_REG_IDX_W 5

// bl writes its return address here
`define LA_LINK_REG 5'd1

`endif
